// ==== rtl/core_pkg.sv ====
// core package: shared widths, load op codes and CSR map for the memory/writeback subsystem
`default_nettype none

package core_pkg;

  localparam int WORD_WD      = 64;
  localparam int GPR_ADDR_WD  = 5;
  localparam int GPR_COUNT    = 32;
  localparam int CSR_ADDR_WD  = 12;
  localparam int MEM_OP_WD    = 3;
  localparam int BYTE_LANES   = WORD_WD / 8;

  // data memory, word indexed by address bits 11:3
  localparam int SRAM_DEPTH   = 512;
  localparam int SRAM_ADDR_WD = $clog2(SRAM_DEPTH);
  localparam int SRAM_IDX_LO  = 3;

  typedef logic [WORD_WD-1:0]      word_t;
  typedef logic [GPR_ADDR_WD-1:0]  gpr_addr_t;
  typedef logic [CSR_ADDR_WD-1:0]  csr_addr_t;
  typedef logic [MEM_OP_WD-1:0]    mem_op_t;     // funct3 of the load
  typedef logic [SRAM_ADDR_WD-1:0] sram_addr_t;

  // load kinds, same encoding as funct3
  localparam mem_op_t MEM_OP_LB  = 3'd0;
  localparam mem_op_t MEM_OP_LH  = 3'd1;
  localparam mem_op_t MEM_OP_LW  = 3'd2;
  localparam mem_op_t MEM_OP_LD  = 3'd3;
  localparam mem_op_t MEM_OP_LBU = 3'd4;
  localparam mem_op_t MEM_OP_LHU = 3'd5;
  localparam mem_op_t MEM_OP_LWU = 3'd6;

  // implemented machine CSRs
  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MTVEC   = 12'h305;
  localparam csr_addr_t CSR_MEPC    = 12'h341;
  localparam csr_addr_t CSR_MCAUSE  = 12'h342;

endpackage

`default_nettype wire

// ==== rtl/es_to_ms_if.sv ====
// execute to memory stage bundle: one instruction's results entering the memory stage
`timescale 1ns/1ns
`default_nettype none

interface es_to_ms_if;
  import core_pkg::*;

  logic      valid;
  gpr_addr_t rd;
  csr_addr_t csr;
  logic      gpr_wen;         // only meaningful with valid
  logic      csr_wen;
  logic      mem_ren;
  mem_op_t   mem_op;
  logic      csr_inst_sel;    // gpr gets csrrdata
  word_t     csrrdata;
  word_t     alu_result;      // also the load byte address
  word_t     csr_result;

  modport producer (
    output valid, rd, csr, gpr_wen, csr_wen, mem_ren, mem_op,
    output csr_inst_sel, csrrdata, alu_result, csr_result
  );

  modport consumer (
    input valid, rd, csr, gpr_wen, csr_wen, mem_ren, mem_op,
    input csr_inst_sel, csrrdata, alu_result, csr_result
  );

endinterface

`default_nettype wire

// ==== rtl/ms_to_ws_if.sv ====
// memory to writeback bundle: final GPR result and CSR write of one instruction
`timescale 1ns/1ns
`default_nettype none

interface ms_to_ws_if;
  import core_pkg::*;

  logic      valid;
  logic      gpr_wen;
  gpr_addr_t rd;
  word_t     gpr_result;    // load, csr or alu value
  logic      csr_wen;
  csr_addr_t csr;
  word_t     csr_result;

  modport producer (
    output valid, gpr_wen, rd, gpr_result, csr_wen, csr, csr_result
  );

  modport consumer (
    input valid, gpr_wen, rd, gpr_result, csr_wen, csr, csr_result
  );

endinterface

`default_nettype wire

// ==== rtl/data_sram.sv ====
// data SRAM: 64-bit words, byte-masked store port, registered read returning the old word
`timescale 1ns/1ns
`default_nettype none

module data_sram (
  input  wire                              i_clk,
  input  wire core_pkg::sram_addr_t        i_raddr,
  output core_pkg::word_t                  o_rdata,
  input  wire                              i_wen,
  input  wire core_pkg::sram_addr_t        i_waddr,
  input  wire core_pkg::word_t             i_wdata,
  input  wire [core_pkg::BYTE_LANES-1:0]   i_wmask
);
  import core_pkg::*;

  word_t mem [SRAM_DEPTH];

  // read port, sampled before this edge's store lands
  always_ff @(posedge i_clk) begin
    o_rdata <= mem[i_raddr];
  end

  // store port
  always_ff @(posedge i_clk) begin
    if (i_wen) begin
      for (int i = 0; i < BYTE_LANES; i++) begin
        if (i_wmask[i]) begin
          mem[i_waddr][i*8 +: 8] <= i_wdata[i*8 +: 8];   // only masked lanes
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/es_ms_reg.sv ====
// execute/memory pipeline register: captures the execute bundle every cycle
`timescale 1ns/1ns
`default_nettype none

module es_ms_reg (
  input  wire                        i_clk,
  input  wire                        i_reset,
  input  wire                        i_es_valid,
  input  wire core_pkg::gpr_addr_t   i_es_rd,
  input  wire core_pkg::csr_addr_t   i_es_csr,
  input  wire                        i_es_gpr_wen,
  input  wire                        i_es_csr_wen,
  input  wire                        i_es_mem_ren,
  input  wire core_pkg::mem_op_t     i_es_mem_op,
  input  wire                        i_es_csr_inst_sel,
  input  wire core_pkg::word_t       i_es_csrrdata,
  input  wire core_pkg::word_t       i_es_alu_result,
  input  wire core_pkg::word_t       i_es_csr_result,
  es_to_ms_if.producer               o_ms
);

  // valid is the only control state
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_ms.valid <= 1'b0;
    end else begin
      o_ms.valid <= i_es_valid;
    end
  end

  // payload, qualified downstream by valid
  always_ff @(posedge i_clk) begin
    o_ms.rd           <= i_es_rd;
    o_ms.csr          <= i_es_csr;
    o_ms.gpr_wen      <= i_es_gpr_wen;
    o_ms.csr_wen      <= i_es_csr_wen;
    o_ms.mem_ren      <= i_es_mem_ren;
    o_ms.mem_op       <= i_es_mem_op;
    o_ms.csr_inst_sel <= i_es_csr_inst_sel;
    o_ms.csrrdata     <= i_es_csrrdata;
    o_ms.alu_result   <= i_es_alu_result;   // low bits pick the load lane
    o_ms.csr_result   <= i_es_csr_result;
  end

endmodule

`default_nettype wire

// ==== rtl/lsu_load.sv ====
// load unit: aligns the addressed byte, half or word of the SRAM word and extends it
`timescale 1ns/1ns
`default_nettype none

module lsu_load (
  input  wire [2:0]                i_raddr_align,
  input  wire core_pkg::word_t     i_data_sram_rdata,
  input  wire core_pkg::mem_op_t   i_mem_op,
  output core_pkg::word_t          o_rdata
);
  import core_pkg::*;

  word_t shifted;

  // bring the addressed lane down to bit 0
  assign shifted = i_data_sram_rdata >> {i_raddr_align, 3'b000};

  always_comb begin
    case (i_mem_op)
      MEM_OP_LB: begin
        o_rdata = {{(WORD_WD-8){shifted[7]}}, shifted[7:0]};
      end
      MEM_OP_LH: begin
        o_rdata = {{(WORD_WD-16){shifted[15]}}, shifted[15:0]};
      end
      MEM_OP_LW: begin
        o_rdata = {{(WORD_WD-32){shifted[31]}}, shifted[31:0]};
      end
      MEM_OP_LBU: begin
        o_rdata = {{(WORD_WD-8){1'b0}}, shifted[7:0]};
      end
      MEM_OP_LHU: begin
        o_rdata = {{(WORD_WD-16){1'b0}}, shifted[15:0]};
      end
      MEM_OP_LWU: begin
        o_rdata = {{(WORD_WD-32){1'b0}}, shifted[31:0]};
      end
      MEM_OP_LD: begin
        o_rdata = i_data_sram_rdata;    // whole word as is
      end
      default: begin
        o_rdata = i_data_sram_rdata;    // funct3 7 is not a load
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/mem_stage.sv ====
// memory stage: picks load data, CSR read data or ALU result as the GPR result
`timescale 1ns/1ns
`default_nettype none

module mem_stage (
  es_to_ms_if.consumer           i_es,
  input  wire core_pkg::word_t   i_data_sram_rdata,
  ms_to_ws_if.producer           o_ws
);
  import core_pkg::*;

  word_t mem_rdata;

  lsu_load u_lsu_load (
    .i_raddr_align     (i_es.alu_result[2:0]),   // byte offset within the word
    .i_data_sram_rdata (i_data_sram_rdata),
    .i_mem_op          (i_es.mem_op),
    .o_rdata           (mem_rdata)
  );

  // load beats csr select
  assign o_ws.gpr_result = i_es.mem_ren      ? mem_rdata :
                           i_es.csr_inst_sel ? i_es.csrrdata :
                                               i_es.alu_result;

  assign o_ws.valid      = i_es.valid;
  assign o_ws.gpr_wen    = i_es.gpr_wen;
  assign o_ws.rd         = i_es.rd;

  // csr write passes straight through
  assign o_ws.csr_wen    = i_es.csr_wen;
  assign o_ws.csr        = i_es.csr;
  assign o_ws.csr_result = i_es.csr_result;

endmodule

`default_nettype wire

// ==== rtl/gpr_file.sv ====
// general register file: 32 x 64 bits, x0 reads zero, one combinational read port
`timescale 1ns/1ns
`default_nettype none

module gpr_file (
  input  wire                        i_clk,
  input  wire                        i_reset,
  input  wire                        i_wen,
  input  wire core_pkg::gpr_addr_t   i_waddr,
  input  wire core_pkg::word_t       i_wdata,
  input  wire core_pkg::gpr_addr_t   i_raddr,
  output core_pkg::word_t            o_rdata
);
  import core_pkg::*;

  word_t regs [GPR_COUNT];

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int i = 0; i < GPR_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;   // x0 never written
    end
  end

  // x0 hardwired
  assign o_rdata = (i_raddr == '0) ? '0 : regs[i_raddr];

endmodule

`default_nettype wire

// ==== rtl/wb_stage.sv ====
// writeback stage: registers memory results, drives GPR writes and holds the machine CSRs
`timescale 1ns/1ns
`default_nettype none

module wb_stage (
  input  wire                        i_clk,
  input  wire                        i_reset,
  ms_to_ws_if.consumer               i_ms,
  output logic                       o_gpr_wen,
  output core_pkg::gpr_addr_t        o_gpr_waddr,
  output core_pkg::word_t            o_gpr_wdata,
  input  wire core_pkg::csr_addr_t   i_csr_raddr,
  output core_pkg::word_t            o_csr_rdata,
  output logic                       o_commit_valid
);
  import core_pkg::*;

  logic      ws_valid;
  logic      ws_gpr_wen;
  logic      ws_csr_wen;
  csr_addr_t ws_csr;
  word_t     ws_csr_result;
  word_t     mstatus;
  word_t     mtvec;
  word_t     mepc;
  word_t     mcause;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ws_valid <= 1'b0;
    end else begin
      ws_valid <= i_ms.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    ws_gpr_wen    <= i_ms.gpr_wen;
    o_gpr_waddr   <= i_ms.rd;
    o_gpr_wdata   <= i_ms.gpr_result;
    ws_csr_wen    <= i_ms.csr_wen;
    ws_csr        <= i_ms.csr;
    ws_csr_result <= i_ms.csr_result;
  end

  assign o_commit_valid = ws_valid;
  assign o_gpr_wen      = ws_valid & ws_gpr_wen;   // gpr file writes at next edge

  // machine csr file, unknown addresses dropped
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (ws_valid && ws_csr_wen) begin
      case (ws_csr)
        CSR_MSTATUS: mstatus <= ws_csr_result;
        CSR_MTVEC:   mtvec   <= ws_csr_result;
        CSR_MEPC:    mepc    <= ws_csr_result;
        CSR_MCAUSE:  mcause  <= ws_csr_result;
        default:     ;
      endcase
    end
  end

  always_comb begin
    case (i_csr_raddr)
      CSR_MSTATUS: o_csr_rdata = mstatus;
      CSR_MTVEC:   o_csr_rdata = mtvec;
      CSR_MEPC:    o_csr_rdata = mepc;
      CSR_MCAUSE:  o_csr_rdata = mcause;
      default:     o_csr_rdata = '0;   // unimplemented reads zero
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/mem_wb_top.sv ====
// memory/writeback top: pipeline register, data SRAM, memory stage, writeback and GPR file
`timescale 1ns/1ns
`default_nettype none

module mem_wb_top (
  input  wire                              i_clk,
  input  wire                              i_reset,
  // execute stage results
  input  wire                              i_es_valid,
  input  wire core_pkg::gpr_addr_t         i_es_rd,
  input  wire core_pkg::csr_addr_t         i_es_csr,
  input  wire                              i_es_gpr_wen,
  input  wire                              i_es_csr_wen,
  input  wire                              i_es_mem_ren,
  input  wire core_pkg::mem_op_t           i_es_mem_op,
  input  wire                              i_es_csr_inst_sel,
  input  wire core_pkg::word_t             i_es_csrrdata,
  input  wire core_pkg::word_t             i_es_alu_result,
  input  wire core_pkg::word_t             i_es_csr_result,
  // store port, byte address
  input  wire                              i_mem_wen,
  input  wire core_pkg::word_t             i_mem_waddr,
  input  wire core_pkg::word_t             i_mem_wdata,
  input  wire [core_pkg::BYTE_LANES-1:0]   i_mem_wmask,
  // debug reads
  input  wire core_pkg::gpr_addr_t         i_gpr_raddr,
  output wire core_pkg::word_t             o_gpr_rdata,
  input  wire core_pkg::csr_addr_t         i_csr_raddr,
  output wire core_pkg::word_t             o_csr_rdata,
  // commit
  output wire                              o_commit_valid,
  output wire                              o_commit_gpr_wen,
  output wire core_pkg::gpr_addr_t         o_commit_rd,
  output wire core_pkg::word_t             o_commit_data
);
  import core_pkg::*;

  es_to_ms_if es_ms ();
  ms_to_ws_if ms_ws ();

  word_t sram_rdata;

  es_ms_reg u_es_ms_reg (
    .i_clk             (i_clk),
    .i_reset           (i_reset),
    .i_es_valid        (i_es_valid),
    .i_es_rd           (i_es_rd),
    .i_es_csr          (i_es_csr),
    .i_es_gpr_wen      (i_es_gpr_wen),
    .i_es_csr_wen      (i_es_csr_wen),
    .i_es_mem_ren      (i_es_mem_ren),
    .i_es_mem_op       (i_es_mem_op),
    .i_es_csr_inst_sel (i_es_csr_inst_sel),
    .i_es_csrrdata     (i_es_csrrdata),
    .i_es_alu_result   (i_es_alu_result),
    .i_es_csr_result   (i_es_csr_result),
    .o_ms              (es_ms.producer)
  );

  // read address issued in the execute cycle so data meets the captured instruction
  data_sram u_data_sram (
    .i_clk   (i_clk),
    .i_raddr (i_es_alu_result[SRAM_IDX_LO +: SRAM_ADDR_WD]),
    .o_rdata (sram_rdata),
    .i_wen   (i_mem_wen),
    .i_waddr (i_mem_waddr[SRAM_IDX_LO +: SRAM_ADDR_WD]),
    .i_wdata (i_mem_wdata),
    .i_wmask (i_mem_wmask)
  );

  mem_stage u_mem_stage (
    .i_es              (es_ms.consumer),
    .i_data_sram_rdata (sram_rdata),
    .o_ws              (ms_ws.producer)
  );

  wb_stage u_wb_stage (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_ms           (ms_ws.consumer),
    .o_gpr_wen      (o_commit_gpr_wen),
    .o_gpr_waddr    (o_commit_rd),
    .o_gpr_wdata    (o_commit_data),
    .i_csr_raddr    (i_csr_raddr),
    .o_csr_rdata    (o_csr_rdata),
    .o_commit_valid (o_commit_valid)
  );

  // commit outputs double as the gpr write port
  gpr_file u_gpr_file (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_wen   (o_commit_gpr_wen),
    .i_waddr (o_commit_rd),
    .i_wdata (o_commit_data),
    .i_raddr (i_gpr_raddr),
    .o_rdata (o_gpr_rdata)
  );

endmodule

`default_nettype wire

// ==== verif/tb_mem_wb.sv ====
// directed testbench for the memory and writeback subsystem against a model of memory, GPRs and CSRs
`timescale 1ns/1ns
`default_nettype none

module tb_mem_wb;
  import core_pkg::*;

  localparam int MAX_CYCLES = 2000;   // all tests take roughly 500 cycles
  // four implemented CSRs and one unimplemented address
  localparam csr_addr_t CSR_LIST [5] = '{CSR_MSTATUS, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE, 12'h7c0};

  typedef struct packed {
    int        due;       // cycle whose negedge shows the commit
    gpr_addr_t rd;
    logic      gpr_wen;
    word_t     data;
  } commit_t;

  logic       i_clk, i_reset, i_es_valid, i_es_gpr_wen, i_es_csr_wen, i_es_mem_ren;
  logic       i_es_csr_inst_sel, i_mem_wen, o_commit_valid, o_commit_gpr_wen;
  gpr_addr_t  i_es_rd, i_gpr_raddr, o_commit_rd;
  csr_addr_t  i_es_csr, i_csr_raddr;
  mem_op_t    i_es_mem_op;
  word_t      i_es_csrrdata, i_es_alu_result, i_es_csr_result;
  word_t      i_mem_waddr, i_mem_wdata, o_gpr_rdata, o_csr_rdata, o_commit_data;
  logic [7:0] i_mem_wmask;

  word_t       mem_model [SRAM_DEPTH];
  word_t       gpr_model [32];
  word_t       csr_model [5];     // last slot stays zero
  sram_addr_t  stored [4];        // words holding known data
  commit_t     expect_q [$];
  logic [31:0] rng_state;
  int          cycles = 0;
  logic        monitor_on;

  mem_wb_top DUT (.*);

  always #2 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Testbench failed");
      $fatal(1);
    end
  end

  task automatic expect_equal(input string name, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  // commits appear in issue order and exactly on their due cycle
  always @(negedge i_clk) begin
    if (monitor_on) begin
      if (expect_q.size() != 0 && expect_q[0].due == cycles) begin
        expect_equal("o_commit_valid", 64'(o_commit_valid), 64'd1);
        expect_equal("o_commit_gpr_wen", 64'(o_commit_gpr_wen), 64'(expect_q[0].gpr_wen));
        expect_equal("o_commit_rd", 64'(o_commit_rd), 64'(expect_q[0].rd));
        expect_equal("o_commit_data", o_commit_data, expect_q[0].data);
        void'(expect_q.pop_front());
      end else begin
        expect_equal("o_commit_valid", 64'(o_commit_valid), 64'd0);
      end
    end
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic word_t rand_word();
    return {next_rand(), next_rand()};
  endfunction

  // low two funct3 bits give the size and bit 2 selects zero extension
  function automatic word_t load_ref(input word_t word, input logic [2:0] offset,
                                     input mem_op_t op);
    int    nbytes;
    word_t value;
    nbytes = 1 << op[1:0];
    value  = '0;
    for (int b = 0; b < nbytes; b++) begin
      value[b*8 +: 8] = word[(offset + b)*8 +: 8];
    end
    if (!op[2] && nbytes < 8 && value[nbytes*8-1]) begin
      for (int b = nbytes*8; b < 64; b++) begin
        value[b] = 1'b1;
      end
    end
    return value;
  endfunction

  task automatic store_word(input word_t addr, input word_t data, input logic [7:0] mask);
    i_mem_wen   = 1'b1;
    i_mem_waddr = addr;
    i_mem_wdata = data;
    i_mem_wmask = mask;
    for (int b = 0; b < 8; b++) begin
      if (mask[b]) begin
        mem_model[addr[11:3]][b*8 +: 8] = data[b*8 +: 8];
      end
    end
    @(posedge i_clk);
    #1;
    i_mem_wen = 1'b0;
  endtask

  task automatic issue(input logic valid, input gpr_addr_t rd, input logic gpr_wen,
                       input logic mem_ren, input mem_op_t op, input logic csr_sel,
                       input int cslot, input logic csr_wen, input word_t alu,
                       input word_t csrrdata, input word_t csr_wdata);
    word_t   result;
    commit_t entry;
    i_es_valid        = valid;
    i_es_rd           = rd;
    i_es_gpr_wen      = gpr_wen;
    i_es_mem_ren      = mem_ren;
    i_es_mem_op       = op;
    i_es_csr_inst_sel = csr_sel;
    i_es_csr          = CSR_LIST[cslot];
    i_es_csr_wen      = csr_wen;
    i_es_alu_result   = alu;
    i_es_csrrdata     = csrrdata;
    i_es_csr_result   = csr_wdata;
    if (mem_ren) begin
      result = load_ref(mem_model[alu[11:3]], alu[2:0], op);
    end else begin
      result = csr_sel ? csrrdata : alu;
    end
    if (valid) begin
      entry = '{due: cycles + 2, rd: rd, gpr_wen: gpr_wen, data: result};
      expect_q.push_back(entry);
      if (gpr_wen && rd != 0) begin
        gpr_model[rd] = result;
      end
      if (csr_wen && cslot < 4) begin
        csr_model[cslot] = csr_wdata;
      end
    end
    @(posedge i_clk);
    #1;
    i_es_valid = 1'b0;
  endtask

  task automatic send_load(input word_t addr, input mem_op_t op);
    issue(1'b1, gpr_addr_t'(next_rand()), 1'b1, 1'b1, op, 1'b0, 0, 1'b0, addr, '0, '0);
  endtask

  task automatic drain();
    while (expect_q.size() != 0) begin
      @(posedge i_clk);
    end
    @(posedge i_clk);
    #1;
  endtask

  // one GPR and one CSR per cycle through the debug ports
  task automatic check_state();
    for (int i = 0; i < 32; i++) begin
      i_gpr_raddr = gpr_addr_t'(i);
      i_csr_raddr = CSR_LIST[i % 5];
      @(negedge i_clk);
      expect_equal("o_gpr_rdata", o_gpr_rdata, gpr_model[i]);
      expect_equal("o_csr_rdata", o_csr_rdata, csr_model[i % 5]);
      @(posedge i_clk);
      #1;
    end
  endtask

  task automatic reset_and_alu();
    check_state();
    for (int r = 1; r < 8; r++) begin
      issue(1'b1, gpr_addr_t'(r), 1'b1, 1'b0, MEM_OP_LD, 1'b0, 0, 1'b0, rand_word(), '0, '0);
    end
    drain();
    check_state();
  endtask

  task automatic all_loads();
    word_t addr;
    for (int w = 0; w < 4; w++) begin
      stored[w] = sram_addr_t'(next_rand());
      store_word({next_rand(), 20'd0, stored[w], 3'd0}, rand_word(), 8'hff);
    end
    for (int w = 0; w < 4; w++) begin
      for (int op = 0; op < 7; op++) begin
        for (int off = 0; off < 8; off += (1 << (op % 4))) begin
          addr = {next_rand(), 20'd0, stored[w], 3'(off)};
          send_load(addr, mem_op_t'(op));
        end
      end
    end
    for (int k = 0; k < 6; k++) begin
      addr = {32'd0, 20'd0, stored[k % 4], 3'd0};
      store_word(addr, rand_word(), 8'(next_rand()));   // partial merge
      send_load(addr, MEM_OP_LD);
    end
    // a load on the same edge as a store gets the old word
    addr        = {32'd0, 20'd0, stored[0], 3'd0};
    i_mem_wen   = 1'b1;
    i_mem_waddr = addr;
    i_mem_wdata = ~mem_model[stored[0]];
    i_mem_wmask = 8'hff;
    send_load(addr, MEM_OP_LD);
    mem_model[stored[0]] = i_mem_wdata;
    i_mem_wen = 1'b0;
    send_load(addr, MEM_OP_LD);
    drain();
    check_state();
  endtask

  task automatic csr_writes();
    for (int k = 0; k < 5; k++) begin
      issue(1'b1, gpr_addr_t'(k + 10), 1'b1, 1'b0, MEM_OP_LD, 1'b1, k, 1'b1,
            rand_word(), rand_word(), rand_word());
    end
    // load flag beats csr select
    issue(1'b1, 5'd20, 1'b1, 1'b1, MEM_OP_LD, 1'b1, 0, 1'b1,
          {32'd0, 20'd0, stored[1], 3'd0}, rand_word(), rand_word());
    drain();
    check_state();
  endtask

  task automatic suppressed_writes();
    issue(1'b1, 5'd0, 1'b1, 1'b0, MEM_OP_LD, 1'b0, 0, 1'b0, rand_word(), '0, '0);
    issue(1'b0, 5'd3, 1'b1, 1'b0, MEM_OP_LD, 1'b0, 0, 1'b1, rand_word(), '0, rand_word());
    issue(1'b1, 5'd4, 1'b0, 1'b0, MEM_OP_LD, 1'b1, 1, 1'b0, '0, rand_word(), rand_word());
    drain();
    check_state();
  endtask

  task automatic random_stream();
    int      kind;
    int      cslot;
    mem_op_t op;
    word_t   addr;
    for (int n = 0; n < 100; n++) begin
      kind  = int'(next_rand() % 3);     // alu, load, csr
      op    = mem_op_t'(next_rand() % 7);
      cslot = int'(next_rand() % 5);
      addr  = {next_rand(), 20'd0, stored[next_rand() % 4],
               3'((next_rand() % (8 >> op[1:0])) << op[1:0])};
      issue((next_rand() % 8) != 0, gpr_addr_t'(next_rand()), (next_rand() % 4) != 0,
            kind == 1, op, kind == 2, cslot, kind == 2, (kind == 1) ? addr : rand_word(),
            rand_word(), rand_word());
    end
    drain();
    check_state();
  endtask

  initial begin
    i_clk             = 1'b0;
    i_reset           = 1'b1;
    i_es_valid        = 1'b0;
    i_es_rd           = '0;
    i_es_csr          = '0;
    i_es_gpr_wen      = 1'b0;
    i_es_csr_wen      = 1'b0;
    i_es_mem_ren      = 1'b0;
    i_es_mem_op       = MEM_OP_LB;
    i_es_csr_inst_sel = 1'b0;
    i_es_csrrdata     = '0;
    i_es_alu_result   = '0;
    i_es_csr_result   = '0;
    i_mem_wen         = 1'b0;
    i_mem_waddr       = '0;
    i_mem_wdata       = '0;
    i_mem_wmask       = '0;
    i_gpr_raddr       = '0;
    i_csr_raddr       = '0;
    rng_state         = 32'h5a00;
    monitor_on        = 1'b0;
    gpr_model         = '{default: '0};
    csr_model         = '{default: '0};
    repeat (8) @(posedge i_clk);
    #1;
    i_reset    = 1'b0;
    monitor_on = 1'b1;
    reset_and_alu();
    all_loads();
    csr_writes();
    suppressed_writes();
    random_stream();
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/core_pkg.sv
rtl/es_to_ms_if.sv
rtl/ms_to_ws_if.sv
rtl/data_sram.sv
rtl/es_ms_reg.sv
rtl/lsu_load.sv
rtl/mem_stage.sv
rtl/gpr_file.sv
rtl/wb_stage.sv
rtl/mem_wb_top.sv
verif/tb_mem_wb.sv

// ==== Makefile ====
# Verilator build and run of the memory/writeback testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_wb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Testbench passed" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
